// File: Makefile
# Verilator build and run of the load/store unit testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/1ns -f src.f --top-module tb_lsu \
		-Mdir obj_dir -o Vtb_lsu

# pass only when the testbench prints its pass line
run: compile
	@out="$$(./obj_dir/Vtb_lsu 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

// File: sim/lsu_vectors.txt
# op (0 load, 1 store)  type (0 word, 1 half, 2 byte)  sign  addr  wdata  exp_rdata  exp_err
# all fields hex, one access per line, memory starts at zero
1 0 0 00000010 11223344 00000000 0
0 0 0 00000010 00000000 11223344 0
1 1 0 00000014 0000beef 00000000 0
1 2 0 00000017 000000a5 00000000 0
0 1 0 00000014 00000000 0000beef 0
0 1 1 00000014 00000000 ffffbeef 0
0 2 0 00000017 00000000 000000a5 0
0 2 1 00000017 00000000 ffffffa5 0
1 0 0 00000018 8f7f80ff 00000000 0
0 2 1 00000018 00000000 ffffffff 0
0 2 1 00000019 00000000 ffffff80 0
0 2 1 0000001a 00000000 0000007f 0
0 2 1 0000001b 00000000 ffffff8f 0
0 1 1 00000018 00000000 ffff80ff 0
0 1 1 00000019 00000000 00007f80 0
0 1 1 0000001a 00000000 ffff8f7f 0
1 0 0 00000021 cafef00d 00000000 0
0 0 0 00000021 00000000 cafef00d 0
1 0 0 0000002a 01234567 00000000 0
0 0 0 0000002a 00000000 01234567 0
1 0 0 00000033 89abcdef 00000000 0
0 0 0 00000033 00000000 89abcdef 0
1 1 0 0000003b 000092e4 00000000 0
0 1 1 0000003b 00000000 ffff92e4 0
0 1 0 0000003b 00000000 000092e4 0
0 0 0 00001000 00000000 00000000 1
1 0 0 00001004 5a5a5a5a 00000000 1
0 0 0 00000ffe 00000000 00000000 1
1 1 0 00000fff 0000c3c3 00000000 1
0 2 1 00001003 00000000 00000000 1
0 0 0 00001ffd 00000000 00000000 1
0 0 0 00000004 00000000 00000000 0

// File: sim/tb_clk_gen.sv
//////////////////////////////////////////////////
// free running testbench clock, 20 ns period
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk_o
);

  // half period of 10 ns
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: sim/tb_lsu.sv
//////////////////////////////////////////////////
// testbench for the load/store unit
// plays the accesses of sim/lsu_vectors.txt against a
// 64-word bus memory with random grant and response delay
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_lsu;

  logic               clk_i;
  logic               rst_ni;
  logic               lsu_req_i;
  logic               lsu_we_i;
  logic               lsu_sign_ext_i;
  lsu_pkg::lsu_type_e lsu_type_i;
  logic [31:0]        lsu_addr_i;
  logic [31:0]        lsu_wdata_i;
  logic [31:0]        lsu_rdata_o;
  logic               lsu_rdata_valid_o;
  logic               lsu_resp_valid_o;
  logic               lsu_req_done_o;
  logic               load_err_o;
  logic               store_err_o;
  logic               busy_o;
  logic [31:0]        addr_last_o;
  logic               data_req_o;
  logic               data_we_o;
  logic               data_gnt_i;
  logic               data_rvalid_i;
  logic               data_bus_err_i;
  logic [31:0]        data_addr_o;
  logic [3:0]         data_be_o;
  logic [31:0]        data_wdata_o;
  logic [31:0]        data_rdata_i;

  // bus memory model state
  logic [31:0] mem [0:63];
  logic [31:0] rsp_data_q [$];
  logic        rsp_err_q [$];
  logic        gnt_ready;
  int          gnt_delay;
  int          rsp_delay;
  int          gnt_count;
  logic [31:0] gnt_addr [0:1];

  // request hold tracking and response pulse count
  logic        hold_valid;
  logic [31:0] hold_addr;
  logic [3:0]  hold_be;
  logic [31:0] hold_wdata;
  logic        exp_we;
  int          resp_count;
  int          access_count;
  int          timeout_cycles = 50;
  integer      seed;

  tb_clk_gen i_clk_gen (
    .clk_o (clk_i)
  );

  lsu_top i_lsu_top (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_we_i          (lsu_we_i),
    .lsu_sign_ext_i    (lsu_sign_ext_i),
    .lsu_type_i        (lsu_type_i),
    .lsu_addr_i        (lsu_addr_i),
    .lsu_wdata_i       (lsu_wdata_i),
    .lsu_rdata_o       (lsu_rdata_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_req_done_o    (lsu_req_done_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o),
    .addr_last_o       (addr_last_o),
    .data_req_o        (data_req_o),
    .data_we_o         (data_we_o),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_bus_err_i    (data_bus_err_i),
    .data_addr_o       (data_addr_o),
    .data_be_o         (data_be_o),
    .data_wdata_o      (data_wdata_o),
    .data_rdata_i      (data_rdata_i)
  );

  // grant only ever answers a live request
  assign data_gnt_i = data_req_o & gnt_ready;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      stop_run($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // random delay from 0 to span-1 cycles
  function automatic int pick_delay(input int span);
    return $unsigned($random(seed)) % span;
  endfunction

  // word off a word boundary, or half-word in the top byte lane
  function automatic logic needs_split(input logic [1:0] acc_type, input logic [31:0] addr);
    return ((acc_type == 2'd0) && (addr[1:0] != 2'd0)) ||
           ((acc_type == 2'd1) && (addr[1:0] == 2'd3));
  endfunction

  //////////////////////////////////////////////////
  // bus memory model
  //////////////////////////////////////////////////

  // accept grants and retire responses at the rising edge
  always @(posedge clk_i) begin : bus_side
    logic [5:0]  idx;
    logic [31:0] rd_word;
    logic        bad_addr;
    logic        was_empty;
    int          b;

    if (data_rvalid_i) begin
      rd_word  = rsp_data_q.pop_front();
      bad_addr = rsp_err_q.pop_front();
      if (rsp_data_q.size() > 0) begin
        rsp_delay = pick_delay(3);
      end
    end else if ((rsp_data_q.size() > 0) && (rsp_delay > 0)) begin
      rsp_delay = rsp_delay - 1;
    end

    if (data_req_o) begin
      check("bus address alignment", 32'd0, 32'(data_addr_o[1:0]));
      // fields stay put while the grant is pending
      if (hold_valid) begin
        check("held bus address", hold_addr, data_addr_o);
        check("held byte enables", 32'(hold_be), 32'(data_be_o));
        check("held store data", hold_wdata, data_wdata_o);
      end
      hold_valid = ~data_gnt_i;
      hold_addr  = data_addr_o;
      hold_be    = data_be_o;
      hold_wdata = data_wdata_o;
    end else begin
      hold_valid = 1'b0;
    end

    if (data_req_o && data_gnt_i) begin
      check("bus write flag", 32'(exp_we), 32'(data_we_o));
      // word (address / 4) mod 64, bit 12 marks a faulting address
      idx      = data_addr_o[7:2];
      bad_addr = data_addr_o[12];
      if (gnt_count < 2) begin
        gnt_addr[gnt_count] = data_addr_o;
      end
      gnt_count = gnt_count + 1;
      if (data_we_o && !bad_addr) begin
        for (b = 0; b < 4; b++) begin
          if (data_be_o[b]) begin
            mem[idx][8*b +: 8] = data_wdata_o[8*b +: 8];
          end
        end
      end
      rd_word   = bad_addr ? 32'h0 : mem[idx];
      was_empty = (rsp_data_q.size() == 0);
      rsp_data_q.push_back(rd_word);
      rsp_err_q.push_back(bad_addr);
      if (was_empty) begin
        rsp_delay = pick_delay(3);
      end
      gnt_delay = pick_delay(4);
    end else if (data_req_o && (gnt_delay > 0)) begin
      gnt_delay = gnt_delay - 1;
    end

    if (lsu_resp_valid_o) begin
      resp_count = resp_count + 1;
    end
  end

  // bus inputs change on the falling edge
  always @(negedge clk_i) begin
    gnt_ready = (gnt_delay == 0);
    if ((rsp_data_q.size() > 0) && (rsp_delay == 0)) begin
      data_rvalid_i  = 1'b1;
      data_rdata_i   = rsp_data_q[0];
      data_bus_err_i = rsp_err_q[0];
    end else begin
      data_rvalid_i  = 1'b0;
      data_rdata_i   = 32'h0;
      data_bus_err_i = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // one access from the execute stage side
  //////////////////////////////////////////////////

  task automatic run_access(input int num, input logic is_store, input logic [1:0] acc_type,
                            input logic sign, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [31:0] exp_rdata, input logic exp_err);
    string       name;
    int          cycles;
    logic        split;
    logic [31:0] first_w;
    logic [31:0] exp_last;

    name    = $sformatf("vector %0d", num);
    split   = needs_split(acc_type, addr);
    first_w = {addr[31:2], 2'b00};
    // last granted part that had no earlier failure
    exp_last = (!split || addr[12]) ? addr : (first_w + 32'd4);

    @(negedge clk_i);
    check({name, " busy before access"}, 32'd0, 32'(busy_o));
    check({name, " bus request before access"}, 32'd0, 32'(data_req_o));
    check({name, " response pulses so far"}, 32'(access_count), 32'(resp_count));
    gnt_count      = 0;
    exp_we         = is_store;
    lsu_req_i      = 1'b1;
    lsu_we_i       = is_store;
    lsu_type_i     = lsu_pkg::lsu_type_e'(acc_type);
    lsu_sign_ext_i = sign;
    lsu_addr_i     = addr;
    lsu_wdata_i    = wdata;

    cycles = 0;
    @(posedge clk_i);
    while (!lsu_req_done_o && (cycles < timeout_cycles)) begin
      @(posedge clk_i);
      cycles = cycles + 1;
    end
    if (!lsu_req_done_o) begin
      stop_run({name, ": timed out waiting for the request to be done"});
    end

    @(negedge clk_i);
    lsu_req_i = 1'b0;

    cycles = 0;
    @(posedge clk_i);
    while (!lsu_resp_valid_o && (cycles < timeout_cycles)) begin
      @(posedge clk_i);
      cycles = cycles + 1;
    end
    if (!lsu_resp_valid_o) begin
      stop_run({name, ": timed out waiting for the response"});
    end

    // response outputs in the response cycle
    check({name, " rdata valid"}, 32'(!is_store && !exp_err), 32'(lsu_rdata_valid_o));
    check({name, " load error"}, 32'(!is_store && exp_err), 32'(load_err_o));
    check({name, " store error"}, 32'(is_store && exp_err), 32'(store_err_o));
    check({name, " last address"}, exp_last, addr_last_o);
    if (!is_store && !exp_err) begin
      check({name, " load data"}, exp_rdata, lsu_rdata_o);
    end

    @(negedge clk_i);
    check({name, " grant count"}, split ? 32'd2 : 32'd1, 32'(gnt_count));
    check({name, " first bus address"}, first_w, gnt_addr[0]);
    if (split) begin
      check({name, " second bus address"}, first_w + 32'd4, gnt_addr[1]);
    end
    check({name, " one response pulse"}, 32'(access_count + 1), 32'(resp_count));
    access_count = access_count + 1;
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin : stimulus
    int          fd;
    int          code;
    int          fields;
    int          num;
    int          i;
    string       line;
    logic [31:0] op;
    logic [31:0] typ;
    logic [31:0] sgn;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic [31:0] exp_err;

    seed           = 32'h9c32435e;
    rst_ni         = 1'b0;
    lsu_req_i      = 1'b0;
    lsu_we_i       = 1'b0;
    lsu_sign_ext_i = 1'b0;
    lsu_type_i     = lsu_pkg::type_word;
    lsu_addr_i     = 32'h0;
    lsu_wdata_i    = 32'h0;
    gnt_ready      = 1'b0;
    data_rvalid_i  = 1'b0;
    data_bus_err_i = 1'b0;
    data_rdata_i   = 32'h0;
    gnt_count      = 0;
    gnt_addr[0]    = 32'h0;
    gnt_addr[1]    = 32'h0;
    hold_valid     = 1'b0;
    exp_we         = 1'b0;
    resp_count     = 0;
    access_count   = 0;
    rsp_delay      = 0;
    gnt_delay      = pick_delay(4);
    for (i = 0; i < 64; i++) begin
      mem[i] = 32'h0;
    end

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // everything quiet out of reset
    @(negedge clk_i);
    check("reset busy", 32'd0, 32'(busy_o));
    check("reset bus request", 32'd0, 32'(data_req_o));
    check("reset request done", 32'd0, 32'(lsu_req_done_o));
    check("reset response valid", 32'd0, 32'(lsu_resp_valid_o));
    check("reset rdata valid", 32'd0, 32'(lsu_rdata_valid_o));
    check("reset load error", 32'd0, 32'(load_err_o));
    check("reset store error", 32'd0, 32'(store_err_o));

    fd = $fopen("sim/lsu_vectors.txt", "r");
    if (fd == 0) begin
      stop_run("could not open the vector file sim/lsu_vectors.txt");
    end
    num = 0;
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      // skip comment and blank lines
      if ((code > 0) && (line.len() > 1) && (line[0] != "#")) begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h",
                         op, typ, sgn, addr, wdata, exp_rdata, exp_err);
        if (fields != 7) begin
          stop_run($sformatf("vector line %0d does not have seven fields", num));
        end
        run_access(num, op[0], typ[1:0], sgn[0], addr, wdata, exp_rdata, exp_err[0]);
        num = num + 1;
      end
    end
    $fclose(fd);

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    check("vectors played", 32'd1, 32'(num > 0));
    check("total response pulses", 32'(access_count), 32'(resp_count));
    check("busy after last access", 32'd0, 32'(busy_o));
    check("bus request after last access", 32'd0, 32'(data_req_o));
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
src/lsu_pkg.sv
src/lsu_ctrl_if.sv
src/lsu_req_fsm.sv
src/lsu_wdata_align.sv
src/lsu_rdata_align.sv
src/lsu_top.sv
sim/tb_clk_gen.sv
sim/tb_lsu.sv

// File: src/lsu_ctrl_if.sv
//////////////////////////////////////////////////
// per-access control between the request FSM and
// the write and read aligners
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

interface lsu_ctrl_if;

  // high while the second half of a split access is requested
  logic second_part;

  // capture offset, type, sign and write flag
  logic ctrl_update;

  // capture the first read word of a split load
  logic rdata_update;

  // registered write flag of the outstanding access
  logic resp_is_store;

  // FSM side drives the strobes and reads back the write flag
  modport fsm (
    output second_part,
    output ctrl_update,
    output rdata_update,
    input  resp_is_store
  );

  // write aligner only needs to know which half is on the bus
  modport wdata (
    input second_part
  );

  // read aligner holds the access control registers
  modport rdata (
    input  ctrl_update,
    input  rdata_update,
    output resp_is_store
  );

endinterface

`default_nettype wire

// File: src/lsu_pkg.sv
//////////////////////////////////////////////////
// shared widths and enums for the load/store unit
// referenced by scoped name from every design file
//////////////////////////////////////////////////

`default_nettype none

package lsu_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // data and address width
  localparam int unsigned xlen = 32;

  // one enable per byte lane
  localparam int unsigned be_width = 4;

  // byte offset inside a word
  localparam int unsigned word_off_width = 2;

  // distance to the next word address
  localparam logic [xlen-1:0] addr_step = 4;

  //////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////

  // access size from the execute stage
  typedef enum logic [1:0] {
    type_word = 2'b00,
    type_half = 2'b01,
    type_byte = 2'b10
  } lsu_type_e;

  // request FSM states
  typedef enum logic [2:0] {
    idle,
    wait_gnt_mis,
    wait_rvalid_mis,
    wait_gnt,
    wait_rvalid_mis_gnts_done
  } ls_state_e;

endpackage

`default_nettype wire

// File: src/lsu_rdata_align.sv
//////////////////////////////////////////////////
// load path of the load/store unit
// joins split read words and extends bytes and
// half-words in the response cycle
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module lsu_rdata_align (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  lsu_pkg::lsu_type_e        lsu_type_i,
  input  logic                      lsu_sign_ext_i,
  input  logic                      lsu_we_i,
  input  logic [lsu_pkg::xlen-1:0]  lsu_addr_i,
  input  logic [lsu_pkg::xlen-1:0]  data_rdata_i,

  lsu_ctrl_if.rdata                 ctrl,

  output logic [lsu_pkg::xlen-1:0]  lsu_rdata_o
);

  lsu_pkg::lsu_type_e type_q;

  logic [lsu_pkg::word_off_width-1:0] offset_q;
  logic                               sign_q;
  logic                               we_q;
  logic                               use_join;
  logic [lsu_pkg::xlen-1:8]           rdata_q;
  logic [lsu_pkg::xlen-1:0]           rdata_join;
  logic [lsu_pkg::xlen-1:0]           rdata_shift;
  logic [lsu_pkg::xlen-1:0]           rdata_sel;

  //////////////////////////////////////////////////
  // access control and first word capture
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      offset_q <= '0;
      type_q   <= lsu_pkg::type_word;
      sign_q   <= 1'b0;
      we_q     <= 1'b0;
    end else if (ctrl.ctrl_update) begin
      offset_q <= lsu_addr_i[lsu_pkg::word_off_width-1:0];
      type_q   <= lsu_type_i;
      sign_q   <= lsu_sign_ext_i;
      we_q     <= lsu_we_i;
    end
  end

  // byte 0 of the first word never belongs to a split load
  always_ff @(posedge clk_i) begin
    if (ctrl.rdata_update) begin
      rdata_q <= data_rdata_i[lsu_pkg::xlen-1:8];
    end
  end

  assign ctrl.resp_is_store = we_q;

  //////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////

  // saved upper bytes of the first word go low
  always_comb begin
    case (offset_q)
      2'd1:    rdata_join = {data_rdata_i[7:0], rdata_q[31:8]};
      2'd2:    rdata_join = {data_rdata_i[15:0], rdata_q[31:16]};
      2'd3:    rdata_join = {data_rdata_i[23:0], rdata_q[31:24]};
      default: rdata_join = data_rdata_i;
    endcase
  end

  // accesses inside one word just shift down
  assign rdata_shift = data_rdata_i >> {offset_q, 3'b000};

  assign use_join = (type_q == lsu_pkg::type_word) ||
                    ((type_q == lsu_pkg::type_half) && (offset_q == '1));

  assign rdata_sel = use_join ? rdata_join : rdata_shift;

  // size select with zero or sign extension
  always_comb begin
    case (type_q)
      lsu_pkg::type_half: lsu_rdata_o = {{16{sign_q & rdata_sel[15]}}, rdata_sel[15:0]};
      lsu_pkg::type_byte: lsu_rdata_o = {{24{sign_q & rdata_sel[7]}}, rdata_sel[7:0]};
      default:            lsu_rdata_o = rdata_sel;
    endcase
  end

  // output select depends on a known access type
  type_known_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(type_q));

endmodule

`default_nettype wire

// File: src/lsu_req_fsm.sv
//////////////////////////////////////////////////
// request FSM of the load/store unit
// splits misaligned accesses, makes the second
// word address and tracks errors and last address
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module lsu_req_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // execute stage request
  input  logic                      lsu_req_i,
  input  lsu_pkg::lsu_type_e        lsu_type_i,
  input  logic [lsu_pkg::xlen-1:0]  lsu_addr_i,

  // bus handshake
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic                      data_bus_err_i,

  lsu_ctrl_if.fsm                   ctrl,

  output logic                      data_req_o,
  output logic [lsu_pkg::xlen-1:0]  data_addr_o,

  // status back to the execute stage
  output logic                      lsu_req_done_o,
  output logic                      lsu_resp_valid_o,
  output logic                      lsu_rdata_valid_o,
  output logic                      load_err_o,
  output logic                      store_err_o,
  output logic                      busy_o,
  output logic [lsu_pkg::xlen-1:0]  addr_last_o
);

  lsu_pkg::ls_state_e state_q, state_d;

  logic mis_q, mis_d;
  logic err_q, err_d;
  logic split_access;
  logic addr_incr;
  logic addr_update;
  logic ctrl_update;
  logic rdata_update;
  logic data_err;

  logic [lsu_pkg::word_off_width-1:0] offset;
  logic [lsu_pkg::xlen-1:0]           addr_first_w;
  logic [lsu_pkg::xlen-1:0]           addr_next;
  logic [lsu_pkg::xlen-1:0]           addr_second_w;
  logic [lsu_pkg::xlen-1:0]           addr_last_q;

  //////////////////////////////////////////////////
  // address generation
  //////////////////////////////////////////////////

  assign offset = lsu_addr_i[lsu_pkg::word_off_width-1:0];

  // word or half-word crossing a word boundary
  assign split_access =
      ((lsu_type_i == lsu_pkg::type_word) && (offset != '0)) ||
      ((lsu_type_i == lsu_pkg::type_half) && (offset == '1));

  assign addr_first_w  = {lsu_addr_i[lsu_pkg::xlen-1:lsu_pkg::word_off_width],
                          {lsu_pkg::word_off_width{1'b0}}};
  assign addr_next     = lsu_addr_i + lsu_pkg::addr_step;
  assign addr_second_w = {addr_next[lsu_pkg::xlen-1:lsu_pkg::word_off_width],
                          {lsu_pkg::word_off_width{1'b0}}};

  // second word selected once the first part is granted
  assign addr_incr   = mis_q | (state_q == lsu_pkg::wait_rvalid_mis_gnts_done);
  assign data_addr_o = addr_incr ? addr_second_w : addr_first_w;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    data_req_o   = 1'b0;
    mis_d        = mis_q;
    err_d        = err_q;
    addr_update  = 1'b0;
    ctrl_update  = 1'b0;
    rdata_update = 1'b0;

    case (state_q)
      lsu_pkg::idle: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          err_d      = 1'b0;
          if (data_gnt_i) begin
            ctrl_update = 1'b1;
            addr_update = 1'b1;
            mis_d       = split_access;
            state_d     = split_access ? lsu_pkg::wait_rvalid_mis : lsu_pkg::idle;
          end else begin
            state_d     = split_access ? lsu_pkg::wait_gnt_mis : lsu_pkg::wait_gnt;
          end
        end
      end

      // first part of a split access waits for its grant
      lsu_pkg::wait_gnt_mis: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update = 1'b1;
          addr_update = 1'b1;
          mis_d       = 1'b1;
          state_d     = lsu_pkg::wait_rvalid_mis;
        end
      end

      // second request goes out while the first response is pending
      lsu_pkg::wait_rvalid_mis: begin
        data_req_o = 1'b1;
        if (data_rvalid_i) begin
          err_d        = data_bus_err_i;
          rdata_update = ~ctrl.resp_is_store;
          // keep the first failing address
          addr_update  = data_gnt_i & ~data_bus_err_i;
          mis_d        = ~data_gnt_i;
          state_d      = data_gnt_i ? lsu_pkg::idle : lsu_pkg::wait_gnt;
        end else if (data_gnt_i) begin
          mis_d   = 1'b0;
          state_d = lsu_pkg::wait_rvalid_mis_gnts_done;
        end
      end

      // aligned access or second part waits for its grant
      lsu_pkg::wait_gnt: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update = 1'b1;
          addr_update = ~err_q;
          mis_d       = 1'b0;
          state_d     = lsu_pkg::idle;
        end
      end

      // both parts granted, first response still outstanding
      lsu_pkg::wait_rvalid_mis_gnts_done: begin
        if (data_rvalid_i) begin
          err_d        = data_bus_err_i;
          addr_update  = ~data_bus_err_i;
          rdata_update = ~ctrl.resp_is_store;
          state_d      = lsu_pkg::idle;
        end
      end

      default: begin
        state_d = lsu_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= lsu_pkg::idle;
      mis_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      mis_q   <= mis_d;
      err_q   <= err_d;
    end
  end

  // last address for the trap value
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update) begin
      addr_last_q <= addr_incr ? addr_second_w : lsu_addr_i;
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  assign ctrl.second_part  = mis_q;
  assign ctrl.ctrl_update  = ctrl_update;
  assign ctrl.rdata_update = rdata_update;

  assign lsu_req_done_o = (lsu_req_i | (state_q != lsu_pkg::idle)) &
                          (state_d == lsu_pkg::idle);

  // final response only arrives with the FSM back in idle
  assign data_err          = err_q | data_bus_err_i;
  assign lsu_resp_valid_o  = data_rvalid_i & (state_q == lsu_pkg::idle);
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~data_err & ~ctrl.resp_is_store;
  assign load_err_o        = lsu_resp_valid_o & data_err & ~ctrl.resp_is_store;
  assign store_err_o       = lsu_resp_valid_o & data_err & ctrl.resp_is_store;

  assign busy_o      = (state_q != lsu_pkg::idle);
  assign addr_last_o = addr_last_q;

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  state_legal_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {lsu_pkg::idle, lsu_pkg::wait_gnt_mis, lsu_pkg::wait_rvalid_mis,
                    lsu_pkg::wait_gnt, lsu_pkg::wait_rvalid_mis_gnts_done});

  addr_aligned_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> (data_addr_o[lsu_pkg::word_off_width-1:0] == '0));

  // the bus side must never grant an idle request line
  gnt_has_req_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_gnt_i |-> data_req_o);

endmodule

`default_nettype wire

// File: src/lsu_top.sv
//////////////////////////////////////////////////
// load/store unit top level
// execute stage on one side, data bus on the other
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module lsu_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // execute stage
  input  logic                          lsu_req_i,
  input  logic                          lsu_we_i,
  input  logic                          lsu_sign_ext_i,
  input  lsu_pkg::lsu_type_e            lsu_type_i,
  input  logic [lsu_pkg::xlen-1:0]      lsu_addr_i,
  input  logic [lsu_pkg::xlen-1:0]      lsu_wdata_i,
  output logic [lsu_pkg::xlen-1:0]      lsu_rdata_o,
  output logic                          lsu_rdata_valid_o,
  output logic                          lsu_resp_valid_o,
  output logic                          lsu_req_done_o,
  output logic                          load_err_o,
  output logic                          store_err_o,
  output logic                          busy_o,
  output logic [lsu_pkg::xlen-1:0]      addr_last_o,

  // data bus
  output logic                          data_req_o,
  output logic                          data_we_o,
  input  logic                          data_gnt_i,
  input  logic                          data_rvalid_i,
  input  logic                          data_bus_err_i,
  output logic [lsu_pkg::xlen-1:0]      data_addr_o,
  output logic [lsu_pkg::be_width-1:0]  data_be_o,
  output logic [lsu_pkg::xlen-1:0]      data_wdata_o,
  input  logic [lsu_pkg::xlen-1:0]      data_rdata_i
);

  // per-access control shared by the three blocks
  lsu_ctrl_if ctrl_if ();

  // write flag is held by the execute stage for the whole request
  assign data_we_o = lsu_we_i;

  lsu_req_fsm i_req_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_type_i        (lsu_type_i),
    .lsu_addr_i        (lsu_addr_i),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_bus_err_i    (data_bus_err_i),
    .ctrl              (ctrl_if.fsm),
    .data_req_o        (data_req_o),
    .data_addr_o       (data_addr_o),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o),
    .addr_last_o       (addr_last_o)
  );

  lsu_wdata_align i_wdata_align (
    .lsu_type_i   (lsu_type_i),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .ctrl         (ctrl_if.wdata),
    .data_be_o    (data_be_o),
    .data_wdata_o (data_wdata_o)
  );

  lsu_rdata_align i_rdata_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_type_i     (lsu_type_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .lsu_we_i       (lsu_we_i),
    .lsu_addr_i     (lsu_addr_i),
    .data_rdata_i   (data_rdata_i),
    .ctrl           (ctrl_if.rdata),
    .lsu_rdata_o    (lsu_rdata_o)
  );

endmodule

`default_nettype wire

// File: src/lsu_wdata_align.sv
//////////////////////////////////////////////////
// store path of the load/store unit
// byte enables and store data lane rotation
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module lsu_wdata_align (
  input  lsu_pkg::lsu_type_e            lsu_type_i,
  input  logic [lsu_pkg::xlen-1:0]      lsu_addr_i,
  input  logic [lsu_pkg::xlen-1:0]      lsu_wdata_i,

  lsu_ctrl_if.wdata                     ctrl,

  output logic [lsu_pkg::be_width-1:0]  data_be_o,
  output logic [lsu_pkg::xlen-1:0]      data_wdata_o
);

  logic [lsu_pkg::word_off_width-1:0] offset;
  logic [lsu_pkg::be_width-1:0]       be_mask;
  logic [2*lsu_pkg::be_width-1:0]     be_wide;
  logic [2*lsu_pkg::xlen-1:0]         wdata_wide;

  assign offset = lsu_addr_i[lsu_pkg::word_off_width-1:0];

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  // lanes of an aligned access of each size
  always_comb begin
    case (lsu_type_i)
      lsu_pkg::type_half: be_mask = 4'b0011;
      lsu_pkg::type_byte: be_mask = 4'b0001;
      default:            be_mask = 4'b1111;
    endcase
  end

  // shifted mask over two words
  // low word is the first part, high word wraps into the second part
  assign be_wide = {{lsu_pkg::be_width{1'b0}}, be_mask} << offset;

  assign data_be_o = ctrl.second_part ? be_wide[2*lsu_pkg::be_width-1:lsu_pkg::be_width]
                                      : be_wide[lsu_pkg::be_width-1:0];

  //////////////////////////////////////////////////
  // store data rotation
  //////////////////////////////////////////////////

  // rotate left by offset bytes, same lanes serve both parts
  assign wdata_wide   = {lsu_wdata_i, lsu_wdata_i} << {offset, 3'b000};
  assign data_wdata_o = wdata_wide[2*lsu_pkg::xlen-1:lsu_pkg::xlen];

  // second part always carries at least one lane
  always_comb begin
    if (ctrl.second_part) begin
      assert (data_be_o != '0)
        else $error("empty byte enables on second part of split access");
    end
  end

endmodule

`default_nettype wire
